// ==== filelist.f ====
rtl/clock_set_pkg.sv
rtl/date_time_if.sv
rtl/button_pulse.sv
rtl/cursor_ctrl.sv
rtl/digit_editor.sv
rtl/weekday_calc.sv
rtl/clock_set_top.sv
verification/tb_clock_set.sv

// ==== rtl/button_pulse.sv ====
`timescale 1ns/1ps

module button_pulse #(
    parameter int HOLD_CYCLES = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    input  logic btn_a,
    input  logic btn_b,
    output logic step_a,
    output logic step_b
);

    localparam int CNT_W = $clog2(HOLD_CYCLES + 2);

    logic [CNT_W-1:0] hold_cnt;
    logic             held;
    logic             fire;

    assign held = enable && (btn_a || btn_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (!held) begin
            hold_cnt <= '0;
        end else if (hold_cnt <= CNT_W'(HOLD_CYCLES)) begin
            hold_cnt <= hold_cnt + 1'b1;  // parks one past threshold so no repeat
        end
    end

    assign fire   = held && (hold_cnt == CNT_W'(HOLD_CYCLES));
    assign step_a = fire && btn_a;  // a wins when both held
    assign step_b = fire && !btn_a;

    a_single_step: assert property (@(posedge clk) disable iff (!rst_n)
        (step_a || step_b) |=> !(step_a || step_b));

endmodule

// ==== rtl/clock_set_pkg.sv ====
package clock_set_pkg;

    typedef logic [3:0]  bcd_digit_t;
    typedef logic [7:0]  bcd_byte_t;    // two bcd digits
    typedef logic [15:0] bcd_year_t;
    typedef logic [3:0]  weekday_t;     // 1 = monday .. 7 = sunday
    typedef logic [83:0] time_string_t;

    // cursor positions, seconds units at 0 up to year thousands at 13
    typedef enum logic [3:0] {
        POS_SEC_U   = 4'd0,
        POS_SEC_T   = 4'd1,
        POS_MIN_U   = 4'd2,
        POS_MIN_T   = 4'd3,
        POS_HOUR_U  = 4'd4,
        POS_HOUR_T  = 4'd5,
        POS_DAY_U   = 4'd6,
        POS_DAY_T   = 4'd7,
        POS_MON_U   = 4'd8,
        POS_MON_T   = 4'd9,
        POS_YEAR_U  = 4'd10,
        POS_YEAR_T  = 4'd11,
        POS_YEAR_H  = 4'd12,
        POS_YEAR_TH = 4'd13
    } digit_pos_t;

    localparam int NUM_DIGITS = 14;

    localparam bcd_digit_t SEPARATOR = 4'hB;  // blank nibble between fields

    localparam bcd_year_t RESET_YEAR  = 16'h2023;
    localparam bcd_byte_t RESET_MONTH = 8'h01;
    localparam bcd_byte_t RESET_DAY   = 8'h01;

endpackage

// ==== rtl/clock_set_top.sv ====
`timescale 1ns/1ps

module clock_set_top
    import clock_set_pkg::*;
#(
    parameter int HOLD_CYCLES = 3
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         set_mode,
    input  logic         button_left,
    input  logic         button_right,
    input  logic         button_up,
    input  logic         button_down,
    output bcd_year_t    year,
    output bcd_byte_t    month,
    output bcd_byte_t    day,
    output bcd_byte_t    hour,
    output bcd_byte_t    minute,
    output bcd_byte_t    second,
    output weekday_t     weekday,
    output digit_pos_t   cursor,
    output time_string_t time_string
);

    logic move_left;
    logic move_right;
    logic step_up;
    logic step_down;

    date_time_if dt_bus ();

    button_pulse #(.HOLD_CYCLES(HOLD_CYCLES)) u_move (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (set_mode),
        .btn_a  (button_left),
        .btn_b  (button_right),
        .step_a (move_left),
        .step_b (move_right)
    );

    button_pulse #(.HOLD_CYCLES(HOLD_CYCLES)) u_step (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (set_mode),
        .btn_a  (button_up),
        .btn_b  (button_down),
        .step_a (step_up),
        .step_b (step_down)
    );

    cursor_ctrl u_cursor (
        .clk        (clk),
        .rst_n      (rst_n),
        .move_left  (move_left),
        .move_right (move_right),
        .cursor     (cursor)
    );

    digit_editor u_editor (
        .clk    (clk),
        .rst_n  (rst_n),
        .inc    (step_up),
        .dec    (step_down),
        .cursor (cursor),
        .dt     (dt_bus.editor)
    );

    weekday_calc u_weekday (
        .clk     (clk),
        .rst_n   (rst_n),
        .dt      (dt_bus.reader),
        .weekday (weekday)
    );

    assign year   = dt_bus.year;
    assign month  = dt_bus.month;
    assign day    = dt_bus.day;
    assign hour   = dt_bus.hour;
    assign minute = dt_bus.minute;
    assign second = dt_bus.second;

    // year mm dd wd hh mm ss, 84 bits
    assign time_string = {dt_bus.year, SEPARATOR, dt_bus.month, SEPARATOR, dt_bus.day,
                          SEPARATOR, weekday, SEPARATOR, dt_bus.hour, SEPARATOR,
                          dt_bus.minute, SEPARATOR, dt_bus.second};

endmodule

// ==== rtl/cursor_ctrl.sv ====
`timescale 1ns/1ps

module cursor_ctrl
    import clock_set_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       move_left,
    input  logic       move_right,
    output digit_pos_t cursor
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor <= POS_YEAR_TH;
        end else if (move_left) begin
            if (cursor == POS_YEAR_TH) begin
                cursor <= POS_SEC_U;  // wrap past the year
            end else begin
                cursor <= digit_pos_t'(cursor + 4'd1);
            end
        end else if (move_right) begin
            if (cursor == POS_SEC_U) begin
                cursor <= POS_YEAR_TH;
            end else begin
                cursor <= digit_pos_t'(cursor - 4'd1);
            end
        end
    end

    a_cursor_range: assert property (@(posedge clk) disable iff (!rst_n)
        cursor < NUM_DIGITS);

endmodule

// ==== rtl/date_time_if.sv ====
`timescale 1ns/1ps

interface date_time_if
    import clock_set_pkg::*;
();

    bcd_year_t year;
    bcd_byte_t month;
    bcd_byte_t day;
    bcd_byte_t hour;
    bcd_byte_t minute;
    bcd_byte_t second;

    modport editor (
        output year, month, day, hour, minute, second
    );

    modport reader (
        input year, month, day, hour, minute, second
    );

endinterface

// ==== rtl/digit_editor.sv ====
`timescale 1ns/1ps

module digit_editor
    import clock_set_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inc,
    input  logic               dec,
    input  digit_pos_t         cursor,
    date_time_if.editor        dt
);

    bcd_digit_t [NUM_DIGITS-1:0] digits;

    bcd_digit_t cur;
    bcd_digit_t lo;
    bcd_digit_t hi;
    logic       is_feb;
    logic       mon_31;
    logic       leap;
    logic       year_top_zero;
    logic [4:0] low_sum;
    logic [4:0] cent_sum;

    assign cur = digits[cursor];

    assign is_feb = ({digits[POS_MON_T], digits[POS_MON_U]} == 8'h02);

    always_comb begin
        case ({digits[POS_MON_T], digits[POS_MON_U]})
            8'h01, 8'h03, 8'h05, 8'h07, 8'h08, 8'h10, 8'h12: mon_31 = 1'b1;
            default: mon_31 = 1'b0;
        endcase
    end

    // 10 = 2 mod 4, so a two digit bcd value divides by 4 when 2*tens + units does
    assign low_sum  = {digits[POS_YEAR_T], 1'b0} + 5'(digits[POS_YEAR_U]);
    assign cent_sum = {digits[POS_YEAR_TH], 1'b0} + 5'(digits[POS_YEAR_H]);

    always_comb begin
        if (digits[POS_YEAR_T] == 4'd0 && digits[POS_YEAR_U] == 4'd0) begin
            leap = (cent_sum[1:0] == 2'd0);  // century year
        end else begin
            leap = (low_sum[1:0] == 2'd0);
        end
    end

    assign year_top_zero = (digits[POS_YEAR_TH] == 4'd0) && (digits[POS_YEAR_H] == 4'd0)
                           && (digits[POS_YEAR_T] == 4'd0);

    // wrap limits of the digit under the cursor
    always_comb begin
        lo = 4'd0;
        hi = 4'd9;
        case (cursor)
            POS_SEC_T, POS_MIN_T: begin
                hi = 4'd5;
            end
            POS_HOUR_T: begin
                hi = 4'd2;
            end
            POS_DAY_U: begin
                if (is_feb && digits[POS_DAY_T] == 4'd2) begin
                    hi = leap ? 4'd9 : 4'd8;
                end else if (mon_31 && digits[POS_DAY_T] == 4'd3) begin
                    hi = 4'd1;
                end else if (!is_feb && digits[POS_DAY_T] == 4'd3) begin
                    hi = 4'd0;  // 30 day month, only day 30
                end else if (digits[POS_DAY_T] == 4'd0) begin
                    lo = 4'd1;
                end
            end
            POS_DAY_T: begin
                hi = is_feb ? 4'd2 : 4'd3;
            end
            POS_MON_U: begin
                if (digits[POS_MON_T] == 4'd1) begin
                    hi = 4'd2;
                end else begin
                    lo = 4'd1;
                end
            end
            POS_MON_T: begin
                hi = 4'd1;
            end
            POS_YEAR_U: begin
                if (year_top_zero) begin
                    lo = 4'd1;  // no year 0000
                end
            end
            default: begin
                hi = 4'd9;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits <= {RESET_YEAR, RESET_MONTH, RESET_DAY, 24'h00_0000};
        end else if (inc) begin
            digits[cursor] <= (cur >= hi) ? lo : cur + 4'd1;
        end else if (dec) begin
            digits[cursor] <= (cur <= lo) ? hi : cur - 4'd1;  // feb day tens 3 drops to 2
        end
    end

    assign dt.year   = digits[POS_YEAR_TH:POS_YEAR_U];
    assign dt.month  = digits[POS_MON_T:POS_MON_U];
    assign dt.day    = digits[POS_DAY_T:POS_DAY_U];
    assign dt.hour   = digits[POS_HOUR_T:POS_HOUR_U];
    assign dt.minute = digits[POS_MIN_T:POS_MIN_U];
    assign dt.second = digits[POS_SEC_T:POS_SEC_U];

    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_bcd_chk
        a_bcd_digit: assert property (@(posedge clk) disable iff (!rst_n)
            digits[i] <= 4'd9);
    end

endmodule

// ==== rtl/weekday_calc.sv ====
`timescale 1ns/1ps

module weekday_calc
    import clock_set_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    date_time_if.reader dt,
    output weekday_t    weekday
);

    logic [15:0] year_bin;
    logic [15:0] mon_bin;
    logic [15:0] day_bin;
    logic [15:0] yf;
    logic [15:0] mf;
    logic [15:0] sum;
    logic [2:0]  rem;
    weekday_t    weekday_d;

    assign year_bin = 16'(dt.year[15:12]) * 16'd1000 + 16'(dt.year[11:8]) * 16'd100
                      + 16'(dt.year[7:4]) * 16'd10 + 16'(dt.year[3:0]);
    assign mon_bin  = 16'(dt.month[7:4]) * 16'd10 + 16'(dt.month[3:0]);
    assign day_bin  = 16'(dt.day[7:4]) * 16'd10 + 16'(dt.day[3:0]);

    always_comb begin
        if (mon_bin == 16'd1 || mon_bin == 16'd2) begin
            mf = mon_bin + 16'd12;  // jan and feb belong to the previous year
            yf = year_bin - 16'd1;
        end else begin
            mf = mon_bin;
            yf = year_bin;
        end
    end

    assign sum = day_bin + (mf << 1) + (16'd3 * (mf + 16'd1)) / 16'd5 + yf + yf / 16'd4
                 - yf / 16'd100 + yf / 16'd400 + 16'd1;
    assign rem = 3'(sum % 16'd7);

    assign weekday_d = (rem == 3'd0) ? 4'd7 : {1'b0, rem};  // 0 is sunday

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weekday <= 4'd7;  // reset date is a sunday
        end else begin
            weekday <= weekday_d;
        end
    end

    a_weekday_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $stable({dt.year, dt.month, dt.day}) |=> $stable(weekday));

endmodule

// ==== verification/tb_clock_set.sv ====
`timescale 1ns/1ps

module tb_clock_set
    import clock_set_pkg::*;
();

    localparam int HOLD        = 3;
    localparam int NUM_PRESSES = 300;  // upper bound over all tests
    localparam int CYCLE_LIMIT = 20 * (NUM_PRESSES + 10);

    logic         clk = 1'b0;
    logic         rst_n;
    logic         set_mode;
    logic         button_left;
    logic         button_right;
    logic         button_up;
    logic         button_down;
    bcd_year_t    year;
    bcd_byte_t    month;
    bcd_byte_t    day;
    bcd_byte_t    hour;
    bcd_byte_t    minute;
    bcd_byte_t    second;
    weekday_t     weekday;
    digit_pos_t   cursor;
    time_string_t time_string;

    bcd_digit_t  md [NUM_DIGITS];  // model digits, index as cursor position
    int          mc;               // model cursor
    int          errors = 0;
    int          cycles = 0;
    int unsigned lcg_state = 21490;

    clock_set_top #(.HOLD_CYCLES(HOLD)) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_mode     (set_mode),
        .button_left  (button_left),
        .button_right (button_right),
        .button_up    (button_up),
        .button_down  (button_down),
        .year         (year),
        .month        (month),
        .day          (day),
        .hour         (hour),
        .minute       (minute),
        .second       (second),
        .weekday      (weekday),
        .cursor       (cursor),
        .time_string  (time_string)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic void model_limits(input int pos, output int lo, output int hi);
        int   yr;
        int   mon;
        logic leap;
        logic long_mon;
        yr       = md[13] * 1000 + md[12] * 100 + md[11] * 10 + md[10];
        mon      = md[9] * 10 + md[8];
        leap     = (yr % 400 == 0) || (yr % 4 == 0 && yr % 100 != 0);
        long_mon = mon inside {1, 3, 5, 7, 8, 10, 12};
        lo = 0;
        hi = 9;
        case (pos)
            1, 3: hi = 5;
            5: hi = 2;
            6: begin
                if (mon == 2 && md[7] == 2) hi = leap ? 9 : 8;
                else if (md[7] == 3 && long_mon) hi = 1;
                else if (md[7] == 3 && mon != 2) hi = 0;  // day 30 only
                else if (md[7] == 0) lo = 1;
            end
            7: hi = (mon == 2) ? 2 : 3;
            8: begin
                if (md[9] == 1) hi = 2;
                else lo = 1;
            end
            9: hi = 1;
            10: if (md[13] == 0 && md[12] == 0 && md[11] == 0) lo = 1;
            default: ;
        endcase
    endfunction

    function automatic weekday_t model_weekday();
        int y;
        int m;
        int d;
        int s;
        y = md[13] * 1000 + md[12] * 100 + md[11] * 10 + md[10];
        m = md[9] * 10 + md[8];
        d = md[7] * 10 + md[6];
        if (m == 1 || m == 2) begin
            m = m + 12;  // counted in the previous year
            y = y - 1;
        end
        s = (d + 2 * m + (3 * (m + 1)) / 5 + y + y / 4 - y / 100 + y / 400 + 1) % 7;
        return (s == 0) ? 4'd7 : weekday_t'(s);
    endfunction

    function automatic time_string_t model_string();
        return {md[13], md[12], md[11], md[10], SEPARATOR, md[9], md[8], SEPARATOR,
                md[7], md[6], SEPARATOR, model_weekday(), SEPARATOR, md[5], md[4],
                SEPARATOR, md[3], md[2], SEPARATOR, md[1], md[0]};
    endfunction

    task automatic check_year(input bcd_year_t got, input bcd_year_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_field(input bcd_byte_t got, input bcd_byte_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_weekday(input weekday_t got, input weekday_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_cursor(input digit_pos_t got, input digit_pos_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_string(input time_string_t got, input time_string_t exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_all();
        @(negedge clk);
        check_year(year, {md[13], md[12], md[11], md[10]}, "year");
        check_field(month, {md[9], md[8]}, "month");
        check_field(day, {md[7], md[6]}, "day");
        check_field(hour, {md[5], md[4]}, "hour");
        check_field(minute, {md[3], md[2]}, "minute");
        check_field(second, {md[1], md[0]}, "second");
        check_weekday(weekday, model_weekday(), "weekday");
        check_cursor(cursor, digit_pos_t'(mc), "cursor");
        check_string(time_string, model_string(), "time_string");
    endtask

    task automatic apply_step(input int which);
        int lo;
        int hi;
        model_limits(mc, lo, hi);
        case (which)
            0: mc = (mc == NUM_DIGITS - 1) ? 0 : mc + 1;
            1: mc = (mc == 0) ? NUM_DIGITS - 1 : mc - 1;
            2: md[mc] = (md[mc] >= hi) ? lo : md[mc] + 1;
            default: md[mc] = (md[mc] <= lo) ? hi : md[mc] - 1;
        endcase
    endtask

    // order left, right, up, down
    task automatic drive_buttons(input logic [3:0] lvl);
        {button_left, button_right, button_up, button_down} <= lvl;
    endtask

    task automatic press_button(input int which);
        @(posedge clk);
        drive_buttons(4'b1000 >> which);
        repeat (10) @(posedge clk);
        drive_buttons(4'b0000);
        repeat (4) @(posedge clk);
        if (set_mode) apply_step(which);
        check_all();
    endtask

    task automatic short_press(input int which);
        @(posedge clk);
        drive_buttons(4'b1000 >> which);
        repeat (HOLD) @(posedge clk);  // released before the threshold
        drive_buttons(4'b0000);
        repeat (4) @(posedge clk);
        check_all();
    endtask

    task automatic move_cursor(input int target);
        int diff;
        diff = (target - mc + NUM_DIGITS) % NUM_DIGITS;
        if (diff <= NUM_DIGITS / 2) repeat (diff) press_button(0);
        else repeat (NUM_DIGITS - diff) press_button(1);
    endtask

    task automatic set_digit(input int pos, input int value);
        int n;
        move_cursor(pos);
        n = 0;
        while (md[pos] != value && n < 10) begin
            press_button(2);
            n++;
        end
        if (md[pos] != value) begin
            errors++;
            $display("digit %0d could not be stepped to %0d within its limits", pos, value);
        end
    endtask

    task automatic set_date(input bcd_year_t y, input bcd_byte_t m, input bcd_byte_t d);
        set_digit(13, y[15:12]);
        set_digit(12, y[11:8]);
        set_digit(11, y[7:4]);
        set_digit(10, y[3:0]);
        set_digit(9, m[7:4]);
        set_digit(8, m[3:0]);
        set_digit(7, d[7:4]);
        set_digit(6, d[3:0]);
    endtask

    task automatic test_reset();
        check_all();
        check_year(year, RESET_YEAR, "reset year");
        check_field(month, RESET_MONTH, "reset month");
        check_field(day, RESET_DAY, "reset day");
        check_field(second, 8'h00, "reset second");
        check_cursor(cursor, POS_YEAR_TH, "reset cursor");
        check_weekday(weekday, 4'd7, "reset weekday");
    endtask

    task automatic test_cursor();
        repeat (NUM_DIGITS) press_button(0);
        check_cursor(cursor, POS_YEAR_TH, "cursor after full left loop");
        press_button(0);
        check_cursor(cursor, POS_SEC_U, "left wrap from position 13");
        press_button(1);
        check_cursor(cursor, POS_YEAR_TH, "right wrap from position 0");
        short_press(0);
        short_press(3);
        @(posedge clk);
        set_mode <= 1'b0;
        press_button(0);
        press_button(2);
        check_cursor(cursor, POS_YEAR_TH, "cursor with set_mode low");
        @(posedge clk);
        set_mode <= 1'b1;
    endtask

    task automatic test_time_fields();
        int        hi_tab [6] = '{9, 5, 9, 5, 9, 2};
        bcd_byte_t exp;
        for (int p = 0; p < 6; p++) begin
            move_cursor(p);
            press_button(3);  // down wrap from 0
            exp = bcd_byte_t'(hi_tab[p] << (4 * (p % 2)));
            case (p / 2)
                0: check_field(second, exp, "second down wrap");
                1: check_field(minute, exp, "minute down wrap");
                default: check_field(hour, exp, "hour down wrap");
            endcase
            press_button(2);
        end
    endtask

    task automatic test_month_day();
        set_date(16'h2024, 8'h02, 8'h29);
        press_button(2);
        check_field(day, 8'h20, "leap february day wrap");
        move_cursor(10);
        press_button(3);
        move_cursor(6);
        press_button(3);
        check_field(day, 8'h28, "february 2023 day wrap");
        set_digit(8, 3);
        set_digit(7, 3);
        move_cursor(8);
        press_button(3);
        move_cursor(7);
        press_button(3);
        check_field(day, 8'h28, "february day tens down from 3");
        set_digit(8, 4);
        set_digit(7, 3);
        move_cursor(6);
        press_button(2);
        press_button(2);
        check_field(day, 8'h30, "30 day month units");
        set_digit(13, 0);
        set_digit(11, 0);
        set_digit(10, 1);
        press_button(3);
        press_button(2);
        check_year(year, 16'h0001, "year units skip 0000");
    endtask

    task automatic test_weekday();
        set_date(16'h2000, 8'h01, 8'h01);
        check_weekday(weekday, 4'd6, "weekday of 2000-01-01");
        set_date(16'h2024, 8'h02, 8'h29);
        check_weekday(weekday, 4'd4, "weekday of 2024-02-29");
    endtask

    task automatic test_random();
        int which;
        repeat (60) begin
            which = (lcg_next() >> 16) % 4;
            press_button(which);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        set_mode = 1'b1;
        {button_left, button_right, button_up, button_down} = 4'b0000;
        md = '{4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd1, 4'd0, 4'd1, 4'd0,
               4'd3, 4'd2, 4'd0, 4'd2};  // 2023-01-01 00:00:00
        mc = NUM_DIGITS - 1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_cursor();
        test_time_fields();
        test_month_day();
        test_weekday();
        test_random();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
